/* hw/sramPkg.sv */
package sramPkg;

   // Basic bus quantities
   typedef logic [7:0] byteT;      // One data byte
   typedef logic [3:0] laneT;      // SIO3 down to SIO0 where lane 0 is SI/SIO0
   typedef logic [7:0] opcodeT;    // Instruction byte
   typedef logic [2:0] byteIdxT;   // Completed bytes in frame up to 4

   // Instruction set
   localparam opcodeT opRead  = 8'h03;   // Read array
   localparam opcodeT opWrite = 8'h02;   // Write array
   localparam opcodeT opRdmr  = 8'h05;   // Read mode register
   localparam opcodeT opWrmr  = 8'h01;   // Write mode register
   localparam opcodeT opEdio  = 8'h3B;   // Enter dual I/O
   localparam opcodeT opEqio  = 8'h38;   // Enter quad I/O
   localparam opcodeT opRstio = 8'hFF;   // Back to single-lane SPI

   // Address bytes after the instruction in a 24-bit bus field
   localparam int addrBytes = 3;

   // Bus width
   typedef enum logic [1:0] {
      ioSpi = 2'b00,   // 1 lane with SI on SIO0 and SO on SIO1
      ioSdi = 2'b01,   // 2 lanes
      ioSqi = 2'b10    // 4 lanes
   } ioModeT;

   // Mode register bits 7:6
   typedef enum logic [1:0] {
      opByte = 2'b00,   // Address holds
      opSeq  = 2'b01,   // Wraps over whole array
      opPage = 2'b10    // Wraps inside one page
   } opModeT;

   // Byte stream from the deserializer
   typedef struct packed {
      logic    active;      // csN low
      logic    byteValid;   // Last bits of a byte on this edge
      byteIdxT byteIdx;     // 0 instr, 1..3 addr, 4 data
      byteT    byteData;    // Assembled byte with MSB first
   } frameT;

   // Load request into the output shifter
   typedef struct packed {
      logic strobe;   // Single-cycle load
      byteT data;     // Byte to shift out
   } txLoadT;

endpackage

/* hw/serialDeserializer.sv */
`timescale 1ns/100ps

module serialDeserializer (
   input  logic             SCK,
   input  logic             rst,
   input  logic             csN,
   input  sramPkg::laneT    sioIn,
   input  sramPkg::ioModeT  ioMode,
   output sramPkg::frameT   frame
);

   sramPkg::byteT   shiftReg;    // Bits received so far in this byte
   sramPkg::byteT   shiftNext;   // Shifter including the lanes on this edge
   sramPkg::byteIdxT byteCnt;    // Bytes completed in the frame
   logic [2:0]      grpCnt;      // Lane groups received in this byte
   logic            lastGroup;

   // Higher lane carries the higher bit
   always_comb begin
      case (ioMode)
         sramPkg::ioSdi: begin
            shiftNext = {shiftReg[5:0], sioIn[1:0]};
            lastGroup = (grpCnt == 3'd3);
         end
         sramPkg::ioSqi: begin
            shiftNext = {shiftReg[3:0], sioIn[3:0]};
            lastGroup = (grpCnt == 3'd1);
         end
         default: begin
            shiftNext = {shiftReg[6:0], sioIn[0]};
            lastGroup = (grpCnt == 3'd7);
         end
      endcase
   end

   // The byte is reported during the cycle whose edge samples its last bits,
   // so the consumer registers it on that same edge
   assign frame.active    = ~csN;
   assign frame.byteValid = ~csN & lastGroup;
   assign frame.byteIdx   = byteCnt;
   assign frame.byteData  = shiftNext;

   always_ff @(posedge SCK) begin
      if (!csN) begin
         shiftReg <= shiftNext;
      end
   end

   always_ff @(posedge SCK) begin
      if (rst || csN) begin
         grpCnt  <= '0;
         byteCnt <= '0;
      end else if (lastGroup) begin
         grpCnt <= '0;
         if (byteCnt <= sramPkg::byteIdxT'(sramPkg::addrBytes)) begin
            byteCnt <= byteCnt + 1'b1;   // Stops at first data index
         end
      end else begin
         grpCnt <= grpCnt + 1'b1;
      end
   end

endmodule

/* hw/commandSequencer.sv */
`timescale 1ns/100ps

module commandSequencer #(
   parameter int AddrWidth = 17,
   parameter int PageBits  = 5
) (
   input  logic                  SCK,
   input  logic                  rst,
   input  sramPkg::frameT        frame,
   output sramPkg::ioModeT       ioMode,
   output logic                  memWe,
   output logic [AddrWidth-1:0]  memAddr,
   output sramPkg::byteT         memWdata,
   input  sramPkg::byteT         memRdata,
   output sramPkg::txLoadT       txLoad
);

   typedef logic [AddrWidth-1:0] addrT;

   typedef enum logic [2:0] {
      instrWait,
      addrCollect,
      writeData,
      readStream,
      modeRead,
      modeWrite,
      ignore
   } seqStateT;

   // Offset bits inside one page
   localparam addrT pageMask = addrT'((1 << PageBits) - 1);

   seqStateT          state;
   sramPkg::opcodeT   instrReg;      // Instruction of this frame
   addrT              addrReg;       // Current array address
   addrT              addrIn;        // Address with the incoming byte appended
   logic [AddrWidth+7:0] addrCat;
   sramPkg::opModeT   opMode;        // Mode register bits 7:6
   logic              loadPending;   // Serializer load on the next edge
   logic              lastAddrByte;

   // Address step after each data byte
   function automatic addrT nextAddr(input addrT cur, input sramPkg::opModeT mode);
      addrT inc;
      inc = cur + 1'b1;
      case (mode)
         sramPkg::opSeq:  nextAddr = inc;
         sramPkg::opPage: nextAddr = (cur & ~pageMask) | (inc & pageMask);
         default:         nextAddr = cur;
      endcase
   endfunction

   // Upper address bits beyond AddrWidth fall off the top
   assign addrCat      = {addrReg, frame.byteData};
   assign addrIn       = addrCat[AddrWidth-1:0];
   assign lastAddrByte = frame.byteValid
                       && (frame.byteIdx == sramPkg::byteIdxT'(sramPkg::addrBytes));

   // Array port
   assign memWe    = (state == writeData) && frame.byteValid;
   assign memWdata = frame.byteData;
   // Start address goes to the array on the edge that completes it
   assign memAddr  = (state == addrCollect) ? addrIn : addrReg;

   assign txLoad.strobe = loadPending;
   assign txLoad.data   = (state == readStream) ? memRdata : {opMode, 6'b000000};

   always_ff @(posedge SCK) begin
      if (rst || !frame.active) begin
         state       <= instrWait;
         loadPending <= 1'b0;
      end else begin
         loadPending <= 1'b0;
         case (state)
            instrWait: begin
               if (frame.byteValid) begin
                  instrReg <= frame.byteData;
                  case (frame.byteData)
                     sramPkg::opRead,
                     sramPkg::opWrite: state <= addrCollect;
                     sramPkg::opRdmr: begin
                        state       <= modeRead;
                        loadPending <= 1'b1;   // Mode byte right after instruction
                     end
                     sramPkg::opWrmr: state <= modeWrite;
                     default:         state <= ignore;   // I/O width or unknown
                  endcase
               end
            end
            addrCollect: begin
               if (frame.byteValid) begin
                  addrReg <= addrIn;
               end
               if (lastAddrByte) begin
                  if (instrReg == sramPkg::opRead) begin
                     state       <= readStream;
                     loadPending <= 1'b1;
                  end else begin
                     state <= writeData;
                  end
               end
            end
            writeData: begin
               if (frame.byteValid) begin
                  addrReg <= nextAddr(addrReg, opMode);
               end
            end
            readStream: begin
               // Address runs one byte ahead of the serializer
               loadPending <= frame.byteValid;
               if (loadPending) begin
                  addrReg <= nextAddr(addrReg, opMode);
               end
            end
            modeRead: begin
               loadPending <= frame.byteValid;   // Mode byte repeats
            end
            modeWrite: begin
               if (frame.byteValid) begin
                  state <= ignore;
               end
            end
            default: ;
         endcase
      end
   end

   // Mode and bus width survive csN high
   always_ff @(posedge SCK) begin
      if (rst) begin
         ioMode <= sramPkg::ioSpi;
         opMode <= sramPkg::opSeq;
      end else if (frame.byteValid) begin
         if (state == instrWait) begin
            case (frame.byteData)
               sramPkg::opEdio:  ioMode <= sramPkg::ioSdi;
               sramPkg::opEqio:  ioMode <= sramPkg::ioSqi;
               sramPkg::opRstio: ioMode <= sramPkg::ioSpi;
               default: ;
            endcase
         end
         if (state == modeWrite) begin
            opMode <= sramPkg::opModeT'(frame.byteData[7:6]);
         end
      end
   end

endmodule

/* hw/sramArray.sv */
`timescale 1ns/100ps

module sramArray #(
   parameter int AddrWidth = 17
) (
   input  logic                  SCK,
   input  logic                  we,
   input  logic [AddrWidth-1:0]  addr,
   input  sramPkg::byteT         wdata,
   output sramPkg::byteT         rdata
);

   localparam int depth = 1 << AddrWidth;

   sramPkg::byteT mem [0:depth-1];   // Contents undefined at power-up

   // Read returns the old contents on a write
   always_ff @(posedge SCK) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];   // One cycle latency
   end

endmodule

/* hw/serialSerializer.sv */
`timescale 1ns/100ps

module serialSerializer (
   input  logic             SCK,
   input  logic             rst,
   input  logic             frameActive,
   input  sramPkg::ioModeT  ioMode,
   input  sramPkg::txLoadT  txLoad,
   output sramPkg::laneT    sioOut,
   output sramPkg::laneT    sioOe
);

   sramPkg::byteT shiftReg;    // Bits still to send
   sramPkg::byteT srcByte;     // New byte on a load, else the shifter
   sramPkg::byteT shiftNext;
   sramPkg::laneT laneBits;    // Top bits mapped onto lanes
   sramPkg::laneT laneMask;    // Lanes driven in this mode

   assign srcByte = txLoad.strobe ? txLoad.data : shiftReg;

   always_comb begin
      case (ioMode)
         sramPkg::ioSdi: begin
            laneBits  = {2'b00, srcByte[7:6]};
            shiftNext = srcByte << 2;
            laneMask  = 4'b0011;
         end
         sramPkg::ioSqi: begin
            laneBits  = srcByte[7:4];
            shiftNext = srcByte << 4;
            laneMask  = 4'b1111;
         end
         default: begin
            // SPI output is SO on lane 1
            laneBits  = {2'b00, srcByte[7], 1'b0};
            shiftNext = srcByte << 1;
            laneMask  = 4'b0010;
         end
      endcase
   end

   always_ff @(posedge SCK) begin
      shiftReg <= shiftNext;
      sioOut   <= laneBits;   // Registered output stage
   end

   // Enables turn on with the first load and stay on for the frame
   always_ff @(posedge SCK) begin
      if (rst || !frameActive) begin
         sioOe <= '0;
      end else if (txLoad.strobe) begin
         sioOe <= laneMask;
      end
   end

endmodule

/* hw/serialSramTop.sv */
`timescale 1ns/100ps

module serialSramTop #(
   parameter int AddrWidth = 17,
   parameter int PageBits  = 5
) (
   input  logic           SCK,
   input  logic           rst,
   input  logic           csN,
   input  sramPkg::laneT  sioIn,
   output sramPkg::laneT  sioOut,
   output sramPkg::laneT  sioOe
);

   sramPkg::frameT        frame;     // Received byte stream
   sramPkg::ioModeT       ioMode;    // Current bus width
   sramPkg::txLoadT       txLoad;
   logic                  memWe;
   logic [AddrWidth-1:0]  memAddr;
   sramPkg::byteT         memWdata;
   sramPkg::byteT         memRdata;

   serialDeserializer rxPath (
      .SCK    (SCK),
      .rst    (rst),
      .csN    (csN),
      .sioIn  (sioIn),
      .ioMode (ioMode),
      .frame  (frame)
   );

   commandSequencer #(
      .AddrWidth (AddrWidth),
      .PageBits  (PageBits)
   ) sequencer (
      .SCK      (SCK),
      .rst      (rst),
      .frame    (frame),
      .ioMode   (ioMode),
      .memWe    (memWe),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memRdata (memRdata),
      .txLoad   (txLoad)
   );

   sramArray #(
      .AddrWidth (AddrWidth)
   ) array (
      .SCK   (SCK),
      .we    (memWe),
      .addr  (memAddr),
      .wdata (memWdata),
      .rdata (memRdata)
   );

   serialSerializer txPath (
      .SCK         (SCK),
      .rst         (rst),
      .frameActive (frame.active),
      .ioMode      (ioMode),
      .txLoad      (txLoad),
      .sioOut      (sioOut),
      .sioOe       (sioOe)
   );

endmodule

/* verification/serialSramHost.svh */
// Host side of the serial bus in the testbench module scope

// Lanes carried per bus cycle in a given width
function automatic int laneCount(input sramPkg::ioModeT io);
   case (io)
      sramPkg::ioSdi: laneCount = 2;
      sramPkg::ioSqi: laneCount = 4;
      default:        laneCount = 1;
   endcase
endfunction

// One lane group for the DUT to sample on the following edge
task automatic driveGroup(input sramPkg::laneT lanes);
   @(posedge SCK);
   csN   <= 1'b0;
   sioIn <= lanes;
endtask

// MSB first with the higher lane on the higher bit
task automatic sendByte(input sramPkg::byteT data);
   int            n;
   sramPkg::byteT rest;
   n    = laneCount(modelIo);
   rest = data;
   for (int g = 0; g < 8 / n; g++) begin
      driveGroup(sramPkg::laneT'(rest >> (8 - n)));
      rest = rest << n;
      @(negedge SCK);
      if (oeQuiet) begin
         checkLanes("sioOe", '0, sioOe);   // Bus still owned by host
      end
   end
endtask

task automatic receiveByte(output sramPkg::byteT data);
   int n;
   n    = laneCount(modelIo);
   data = '0;
   for (int g = 0; g < 8 / n; g++) begin
      driveGroup('0);
      @(negedge SCK);
      if (modelIo == sramPkg::ioSpi) begin
         data = {data[6:0], sioOut[1]};   // SO sits on lane 1
      end else begin
         data = (data << n) | sramPkg::byteT'(sioOut & sramPkg::laneT'((1 << n) - 1));
      end
   end
endtask

task automatic endFrame();
   @(posedge SCK);
   csN   <= 1'b1;
   sioIn <= '0;
   @(posedge SCK);   // DUT sees csN high here
endtask

// Instruction plus the three address bytes
task automatic startAccess(input sramPkg::opcodeT op, input logic [23:0] addr);
   sendByte(op);
   for (int i = 2; i >= 0; i--) begin
      sendByte(addr[8*i +: 8]);
   end
endtask

task automatic setOpMode(input sramPkg::opModeT mode);
   sendByte(sramPkg::opWrmr);
   sendByte({mode, 6'b000000});
   endFrame();
endtask

// RDMR returning the first copy and its repeat
task automatic fetchModeByte(output sramPkg::byteT first, output sramPkg::byteT second);
   sendByte(sramPkg::opRdmr);
   driveGroup('0);   // Output starts one edge after the instruction
   receiveByte(first);
   receiveByte(second);
   endFrame();
endtask

// New width applies from the next frame
task automatic switchIo(input sramPkg::opcodeT op, input sramPkg::ioModeT newIo);
   sendByte(op);
   endFrame();
   modelIo = newIo;
endtask

/* verification/serialSramTb.sv */
`timescale 1ns/100ps

module serialSramTb;

   localparam int addrWidth = 17;
   localparam int depth     = 1 << addrWidth;

   typedef logic [addrWidth-1:0] addrT;

   // Cycles of one frame including turnaround and the closing cycles
   function automatic int frameCycles(input int bytes, input int lanes);
      frameCycles = bytes * (8 / lanes) + 3;
   endfunction

   localparam int cycleLimit = 2 * (5 + frameCycles(5, 1)
      + frameCycles(2, 1) + 2 * frameCycles(44, 1)
      + 3 * (frameCycles(2, 1) + frameCycles(3, 1))
      + 3 * frameCycles(2, 1) + frameCycles(20, 1) + frameCycles(44, 1) + frameCycles(52, 1)
      + frameCycles(2, 1) + frameCycles(10, 1) + frameCycles(8, 1)
      + frameCycles(2, 1) + frameCycles(1, 1) + 2 * frameCycles(20, 2) + frameCycles(1, 2)
      + 2 * frameCycles(20, 4) + frameCycles(1, 4) + frameCycles(3, 1)) + 1000;

   logic          SCK;
   logic          rst;
   logic          csN;
   sramPkg::laneT sioIn;
   sramPkg::laneT sioOut;
   sramPkg::laneT sioOe;

   sramPkg::byteT   modelMem [0:depth-1];
   bit              modelValid [0:depth-1];   // Byte written at least once
   sramPkg::opModeT modelMode;
   sramPkg::ioModeT modelIo;

   bit     oeQuiet;   // Enables must stay off while the host sends
   integer seed;
   int     checks;
   int     errors;
   int     cycles = 0;

   serialSramTop uut (
      .SCK    (SCK),
      .rst    (rst),
      .csN    (csN),
      .sioIn  (sioIn),
      .sioOut (sioOut),
      .sioOe  (sioOe)
   );

   initial begin
      SCK = 1'b0;
      forever #2 SCK = ~SCK;
   end

   always @(posedge SCK) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         $display("ERROR: run did not finish within %0d clock cycles", cycleLimit);
         $display("Regression failed");
         $finish;
      end
   end

   task automatic checkByte(input string name, input sramPkg::byteT expected,
                            input sramPkg::byteT actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic checkLanes(input string name, input sramPkg::laneT expected,
                             input sramPkg::laneT actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
      end
   endtask

   task automatic checkMode(input sramPkg::opModeT expected, input sramPkg::opModeT actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH at %0t: mode bits expected %b, got %b", $time, expected, actual);
      end
   endtask

`include "serialSramHost.svh"

   // Address step of the mode register
   function automatic addrT modelNext(input addrT addr);
      case (modelMode)
         sramPkg::opPage: modelNext = {addr[addrWidth-1:5], addr[4:0] + 5'd1};
         sramPkg::opSeq:  modelNext = addr + 1'b1;
         default:         modelNext = addr;
      endcase
   endfunction

   // Lanes the DUT drives while it owns the bus
   function automatic sramPkg::laneT outputLanes(input sramPkg::ioModeT io);
      case (io)
         sramPkg::ioSdi: outputLanes = 4'b0011;
         sramPkg::ioSqi: outputLanes = 4'b1111;
         default:        outputLanes = 4'b0010;   // SO only
      endcase
   endfunction

   task automatic applyReset();
      rst <= 1'b1;
      repeat (5) @(posedge SCK);
      rst <= 1'b0;
   endtask

   task automatic writeBurst(input addrT start, input int count);
      addrT          addr;
      sramPkg::byteT data;
      addr = start;
      startAccess(sramPkg::opWrite, 24'(start));
      for (int i = 0; i < count; i++) begin
         data = sramPkg::byteT'($random(seed));
         sendByte(data);
         modelMem[addr]   = data;
         modelValid[addr] = 1'b1;
         addr = modelNext(addr);
      end
      endFrame();
   endtask

   task automatic readBurst(input addrT start, input int count);
      addrT          addr;
      sramPkg::byteT data;
      addr = start;
      startAccess(sramPkg::opRead, 24'(start));
      driveGroup('0);   // First byte leaves one edge after the address
      for (int i = 0; i < count; i++) begin
         receiveByte(data);
         if (modelValid[addr]) begin
            checkByte("sioOut read data", modelMem[addr], data);
         end
         addr = modelNext(addr);
      end
      checkLanes("sioOe", outputLanes(modelIo), sioOe);
      endFrame();
   endtask

   task automatic writeModeReg(input sramPkg::opModeT mode);
      setOpMode(mode);
      modelMode = mode;
   endtask

   task automatic verifyModeReg();
      sramPkg::byteT first;
      sramPkg::byteT second;
      fetchModeByte(first, second);
      checkMode(modelMode, sramPkg::opModeT'(first[7:6]));
      checkByte("sioOut mode byte", {modelMode, 6'b000000}, first);
      checkByte("sioOut mode repeat", {modelMode, 6'b000000}, second);
   endtask

   task automatic reportTest(input int num, input string name, input int errStart);
      if (errors == errStart) begin
         $display("Test %0d %s: ok", num, name);
      end else begin
         $display("Test %0d %s: %0d mismatches", num, name, errors - errStart);
      end
   endtask

   initial begin
      sramPkg::byteT   data;
      sramPkg::opModeT order [0:2];
      sramPkg::opModeT tmp;
      addrT            start;
      int              errStart;
      int              j;
      seed      = 32'ha8fa_6dcb;
      rst       = 1'b1;
      csN       = 1'b1;
      sioIn     = '0;
      modelMode = sramPkg::opSeq;   // Reset values
      modelIo   = sramPkg::ioSpi;
      oeQuiet   = 1'b0;
      checks    = 0;
      errors    = 0;
      applyReset();

      errStart = errors;
      @(negedge SCK);
      checkLanes("sioOe", '0, sioOe);
      oeQuiet = 1'b1;
      startAccess(sramPkg::opRead, 24'h0);
      oeQuiet = 1'b0;
      driveGroup('0);
      receiveByte(data);   // Unwritten contents
      checkLanes("sioOe", 4'b0010, sioOe);
      endFrame();
      @(negedge SCK);
      checkLanes("sioOe", '0, sioOe);
      reportTest(6, "output enables", errStart);

      errStart = errors;
      writeModeReg(sramPkg::opSeq);
      start = addrT'($random(seed));
      writeBurst(start, 40);
      readBurst(start, 40);
      reportTest(1, "SPI sequential burst", errStart);

      errStart = errors;
      order[0] = sramPkg::opByte;
      order[1] = sramPkg::opPage;
      order[2] = sramPkg::opSeq;
      for (int i = 2; i > 0; i--) begin
         j        = $unsigned($random(seed)) % (i + 1);
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < 3; i++) begin
         writeModeReg(order[i]);
         verifyModeReg();
      end
      reportTest(2, "mode register", errStart);

      errStart = errors;
      writeModeReg(sramPkg::opSeq);
      writeBurst('0, 16);   // Target of the wrap at the array end
      writeModeReg(sramPkg::opPage);
      start = addrT'(depth - 12 + $unsigned($random(seed)) % 12);
      writeBurst(start, 40);
      writeModeReg(sramPkg::opSeq);
      readBurst(addrT'(depth - 32), 48);
      reportTest(3, "page wrap", errStart);

      errStart = errors;
      writeModeReg(sramPkg::opByte);
      start = addrT'($random(seed));
      writeBurst(start, 6);
      readBurst(start, 4);
      reportTest(4, "byte mode", errStart);

      errStart = errors;
      writeModeReg(sramPkg::opSeq);
      switchIo(sramPkg::opEdio, sramPkg::ioSdi);
      start = addrT'($random(seed));
      writeBurst(start, 16);
      readBurst(start, 16);
      switchIo(sramPkg::opEqio, sramPkg::ioSqi);
      start = addrT'($random(seed));
      writeBurst(start, 16);
      readBurst(start, 16);
      switchIo(sramPkg::opRstio, sramPkg::ioSpi);
      verifyModeReg();
      reportTest(5, "dual and quad I/O", errStart);

      $display("Tests run: 6, checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* filelist.f */
+incdir+verification
hw/sramPkg.sv
hw/serialDeserializer.sv
hw/commandSequencer.sv
hw/sramArray.sv
hw/serialSerializer.sv
hw/serialSramTop.sv
verification/serialSramTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the serial SRAM regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
   --top-module serialSramTb \
   -f filelist.f \
   --Mdir obj_dir \
   -o serialSramSim

./obj_dir/serialSramSim > sim.log
cat sim.log

if grep -q "Regression failed" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi

echo "Simulation finished, see sim.log"
